// File: hdl/cc_pkg.sv
package cc_pkg;

  // ------------------------------------------------------------
  // Configuration
  // ------------------------------------------------------------
  localparam logic [31:0] boot_addr = 32'h0000_1000;
  localparam int unsigned id_width  = 5;

  // Register (1) or bypass (0) the offload spill registers
  localparam bit reg_offload_req  = 1'b1;
  localparam bit reg_offload_resp = 1'b1;

  // ------------------------------------------------------------
  // Encodings
  // ------------------------------------------------------------
  localparam logic [6:0] opc_op        = 7'b0110011;
  localparam logic [6:0] opc_op_imm    = 7'b0010011;
  localparam logic [6:0] funct7_muldiv = 7'b0000001;
  localparam logic [2:0] f3_addi       = 3'b000;

  // RV32M operations, equal to funct3
  localparam logic [2:0] md_mul    = 3'b000;
  localparam logic [2:0] md_mulh   = 3'b001;
  localparam logic [2:0] md_mulhsu = 3'b010;
  localparam logic [2:0] md_mulhu  = 3'b011;
  localparam logic [2:0] md_div    = 3'b100;
  localparam logic [2:0] md_divu   = 3'b101;
  localparam logic [2:0] md_rem    = 3'b110;
  localparam logic [2:0] md_remu   = 3'b111;

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_type;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_type;
  } inst_t;

endpackage

// File: hdl/spill_register.sv
module spill_register #(
  parameter int unsigned width  = 32,
  parameter bit          bypass = 1'b0
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [width-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [width-1:0] data_o
);

  if (bypass) begin : g_bypass
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : g_spill
    logic             out_full, spl_full;
    logic [width-1:0] out_data, spl_data;
    logic             out_free;

    // Output slot can take a new item this cycle
    assign out_free = !out_full || ready_i;

    assign valid_o = out_full;
    assign data_o  = out_data;
    assign ready_o = !spl_full;

    always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
        out_full <= 1'b0;
        spl_full <= 1'b0;
      end else if (out_free) begin
        out_full <= spl_full || valid_i;
        spl_full <= 1'b0;
      end else if (valid_i && !spl_full) begin
        spl_full <= 1'b1;
      end
    end

    // Older item in the spill slot moves forward first
    always_ff @(posedge clk_i) begin
      if (out_free) begin
        out_data <= spl_full ? spl_data : data_i;
      end else if (valid_i && !spl_full) begin
        spl_data <= data_i;
      end
    end
  end

endmodule

// File: hdl/cc_fetch.sv
module cc_fetch (
  input  logic           clk_i,
  input  logic           rst_i,
  output logic [31:0]    inst_addr_o,
  input  logic [31:0]    inst_data_i,
  output logic           inst_valid_o,
  input  logic           inst_ready_i,
  input  logic           stall_i,
  output logic           fetch_valid_o,
  output cc_pkg::inst_t  fetch_word_o,
  output logic [31:0]    fetch_pc_o
);

  import cc_pkg::*;

  logic [31:0] pc;
  logic        run_q, hold_full, xfer;

  // Next request goes out as soon as the held word is consumed
  assign inst_valid_o  = run_q && (!hold_full || !stall_i);
  assign inst_addr_o   = pc;
  assign xfer          = inst_valid_o && inst_ready_i;
  assign fetch_valid_o = hold_full;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      run_q     <= 1'b0;
      hold_full <= 1'b0;
      pc        <= boot_addr;
    end else begin
      run_q     <= 1'b1;
      hold_full <= xfer || (hold_full && stall_i);
      if (xfer) begin
        pc <= pc + 32'd4;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (xfer) begin
      fetch_word_o <= inst_data_i;
      fetch_pc_o   <= pc;
    end
  end

endmodule

// File: hdl/cc_core.sv
module cc_core (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        fetch_valid_i,
  input  cc_pkg::inst_t               fetch_word_i,
  output logic                        stall_o,
  output logic [4:0]                  rs1_addr_o,
  output logic [4:0]                  rs2_addr_o,
  input  logic [31:0]                 rs1_data_i,
  input  logic [31:0]                 rs2_data_i,
  output logic                        alu_valid_o,
  output logic [4:0]                  alu_rd_o,
  output logic [31:0]                 alu_data_o,
  output logic                        req_valid_o,
  input  logic                        req_ready_i,
  output logic [2:0]                  req_op_o,
  output logic [31:0]                 req_arga_o,
  output logic [31:0]                 req_argb_o,
  output logic [cc_pkg::id_width-1:0] req_id_o,
  input  logic                        clear_valid_i,
  input  logic [cc_pkg::id_width-1:0] clear_rd_i,
  output logic                        illegal_o
);

  import cc_pkg::*;

  logic [31:0] pending;
  logic [4:0]  rs1, rs2, rd;
  logic        is_addi, is_md, hazard;
  logic [31:0] rs1_val, rs2_val, imm_ext;

  // ------------------------------------------------------------
  // Decode
  // ------------------------------------------------------------
  assign rs1 = fetch_word_i.r_type.rs1;
  assign rs2 = fetch_word_i.r_type.rs2;
  assign rd  = fetch_word_i.r_type.rd;

  assign is_addi = (fetch_word_i.i_type.opcode == opc_op_imm) &&
                   (fetch_word_i.i_type.funct3 == f3_addi);
  assign is_md   = (fetch_word_i.r_type.opcode == opc_op) &&
                   (fetch_word_i.r_type.funct7 == funct7_muldiv);
  assign imm_ext = {{20{fetch_word_i.i_type.imm[11]}}, fetch_word_i.i_type.imm};

  // rs2 only matters for register-register forms
  assign hazard  = pending[rs1] || (is_md && pending[rs2]) || pending[rd];

  assign stall_o   = fetch_valid_i && (is_addi || is_md) &&
                     (hazard || (is_md && !req_ready_i));
  assign illegal_o = fetch_valid_i && !is_addi && !is_md;

  assign rs1_addr_o = rs1;
  assign rs2_addr_o = rs2;

  // Last ALU result is not yet in the register file
  assign rs1_val = (alu_valid_o && alu_rd_o == rs1 && rs1 != '0) ? alu_data_o : rs1_data_i;
  assign rs2_val = (alu_valid_o && alu_rd_o == rs2 && rs2 != '0) ? alu_data_o : rs2_data_i;

  // ------------------------------------------------------------
  // Offload issue
  // ------------------------------------------------------------
  assign req_valid_o = fetch_valid_i && is_md && !hazard;
  assign req_op_o    = fetch_word_i.r_type.funct3;
  assign req_arga_o  = rs1_val;
  assign req_argb_o  = rs2_val;
  assign req_id_o    = rd;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      pending     <= '0;
      alu_valid_o <= 1'b0;
    end else begin
      alu_valid_o <= fetch_valid_i && is_addi && !hazard;
      if (clear_valid_i) begin
        pending[clear_rd_i] <= 1'b0;
      end
      if (req_valid_o && req_ready_i && rd != '0) begin
        pending[rd] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    alu_rd_o   <= rd;
    alu_data_o <= rs1_val + imm_ext;
  end

endmodule

// File: hdl/cc_muldiv.sv
module cc_muldiv (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        req_valid_i,
  output logic                        req_ready_o,
  input  logic [2:0]                  req_op_i,
  input  logic [31:0]                 req_arga_i,
  input  logic [31:0]                 req_argb_i,
  input  logic [cc_pkg::id_width-1:0] req_id_i,
  output logic                        resp_valid_o,
  input  logic                        resp_ready_i,
  output logic [31:0]                 resp_data_o,
  output logic [cc_pkg::id_width-1:0] resp_id_o
);

  import cc_pkg::*;

  logic               busy, req_xfer, is_div, div_sgn, a_neg, b_neg;
  logic               mul_asgn, mul_bsgn;
  logic signed [65:0] mul_prod;
  logic [31:0]        mul_res;
  logic [5:0]         div_cnt;
  logic [31:0]        div_rem, div_quo, div_dvs, div_q, div_r;
  logic               div_negq, div_negr, div_isrem;
  logic [32:0]        rem_shift;
  logic [33:0]        rem_diff;

  assign req_ready_o = !busy && (!resp_valid_o || resp_ready_i);
  assign req_xfer    = req_valid_i && req_ready_o;
  assign is_div      = req_op_i[2];

  // ------------------------------------------------------------
  // Multiplier
  // ------------------------------------------------------------
  assign mul_asgn = (req_op_i == md_mulh) || (req_op_i == md_mulhsu);
  assign mul_bsgn = (req_op_i == md_mulh);
  assign mul_prod = $signed({mul_asgn & req_arga_i[31], req_arga_i}) *
                    $signed({mul_bsgn & req_argb_i[31], req_argb_i});
  assign mul_res  = (req_op_i == md_mul) ? mul_prod[31:0] : mul_prod[63:32];

  // ------------------------------------------------------------
  // Divider, one quotient bit per cycle
  // ------------------------------------------------------------
  assign div_sgn   = (req_op_i == md_div) || (req_op_i == md_rem);
  assign a_neg     = div_sgn && req_arga_i[31];
  assign b_neg     = div_sgn && req_argb_i[31];
  assign rem_shift = {div_rem, div_quo[31]};
  assign rem_diff  = {1'b0, rem_shift} - {2'b00, div_dvs};
  assign div_q     = div_negq ? -div_quo : div_quo;
  assign div_r     = div_negr ? -div_rem : div_rem;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      busy         <= 1'b0;
      resp_valid_o <= 1'b0;
    end else begin
      if (resp_valid_o && resp_ready_i) begin
        resp_valid_o <= 1'b0;
      end
      if (req_xfer) begin
        busy         <= is_div;
        resp_valid_o <= !is_div;
      end else if (busy && div_cnt == 6'd32) begin
        busy         <= 1'b0;
        resp_valid_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_xfer) begin
      resp_id_o <= req_id_i;
      if (!is_div) begin
        resp_data_o <= mul_res;
      end
      div_cnt   <= '0;
      div_rem   <= '0;
      div_quo   <= a_neg ? -req_arga_i : req_arga_i;
      div_dvs   <= b_neg ? -req_argb_i : req_argb_i;
      // Division by zero keeps the all-ones quotient
      div_negq  <= (a_neg ^ b_neg) && (req_argb_i != '0);
      div_negr  <= a_neg;
      div_isrem <= req_op_i[1];
    end else if (busy) begin
      div_cnt <= div_cnt + 6'd1;
      if (div_cnt == 6'd32) begin
        resp_data_o <= div_isrem ? div_r : div_q;
      end else if (!rem_diff[33]) begin
        div_rem <= rem_diff[31:0];
        div_quo <= {div_quo[30:0], 1'b1};
      end else begin
        div_rem <= rem_shift[31:0];
        div_quo <= {div_quo[30:0], 1'b0};
      end
    end
  end

endmodule

// File: hdl/cc_writeback.sv
module cc_writeback (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        alu_valid_i,
  input  logic [4:0]                  alu_rd_i,
  input  logic [31:0]                 alu_data_i,
  input  logic                        resp_valid_i,
  output logic                        resp_ready_o,
  input  logic [31:0]                 resp_data_i,
  input  logic [cc_pkg::id_width-1:0] resp_id_i,
  input  logic [4:0]                  rs1_addr_i,
  input  logic [4:0]                  rs2_addr_i,
  output logic [31:0]                 rs1_data_o,
  output logic [31:0]                 rs2_data_o,
  output logic                        clear_valid_o,
  output logic [4:0]                  clear_rd_o,
  output logic                        retire_valid_o,
  output logic [4:0]                  retire_rd_o,
  output logic [31:0]                 retire_data_o
);

  logic [31:0] regs [31:1];
  logic        wr_valid;
  logic [4:0]  wr_rd;
  logic [31:0] wr_data;

  // ALU wins, offload response waits a cycle
  assign resp_ready_o  = !alu_valid_i;
  assign clear_valid_o = resp_valid_i && !alu_valid_i;
  assign clear_rd_o    = resp_id_i;

  assign wr_valid = alu_valid_i || clear_valid_o;
  assign wr_rd    = alu_valid_i ? alu_rd_i : resp_id_i;
  assign wr_data  = alu_valid_i ? alu_data_i : resp_data_i;

  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
      retire_valid_o <= 1'b0;
    end else begin
      retire_valid_o <= wr_valid;
      if (wr_valid && wr_rd != '0) begin
        regs[wr_rd] <= wr_data;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    retire_rd_o   <= wr_rd;
    retire_data_o <= (wr_rd == '0) ? '0 : wr_data;
  end

endmodule

// File: hdl/cc_complex.sv
module cc_complex (
  input  logic        clk_i,
  input  logic        rst_i,
  output logic [31:0] inst_addr_o,
  input  logic [31:0] inst_data_i,
  output logic        inst_valid_o,
  input  logic        inst_ready_i,
  output logic        retire_valid_o,
  output logic [4:0]  retire_rd_o,
  output logic [31:0] retire_data_o,
  output logic        illegal_o
);

  import cc_pkg::*;

  inst_t               fetch_word;
  logic                fetch_valid, stall;
  logic [4:0]          rs1_addr, rs2_addr, alu_rd, clear_rd;
  logic [31:0]         rs1_data, rs2_data, alu_data;
  logic                alu_valid, clear_valid;

  // Offload request, before and after the spill register
  logic                req_d_valid, req_d_ready, req_q_valid, req_q_ready;
  logic [2:0]          req_d_op, req_q_op;
  logic [31:0]         req_d_arga, req_d_argb, req_q_arga, req_q_argb;
  logic [id_width-1:0] req_d_id, req_q_id;

  // Offload response
  logic                resp_d_valid, resp_d_ready, resp_q_valid, resp_q_ready;
  logic [31:0]         resp_d_data, resp_q_data;
  logic [id_width-1:0] resp_d_id, resp_q_id;

  cc_fetch i_fetch (
    .clk_i, .rst_i, .inst_addr_o, .inst_data_i, .inst_valid_o, .inst_ready_i,
    .stall_i       ( stall       ),
    .fetch_valid_o ( fetch_valid ),
    .fetch_word_o  ( fetch_word  ),
    .fetch_pc_o    (             )
  );

  cc_core i_core (
    .clk_i, .rst_i,
    .fetch_valid_i ( fetch_valid ), .fetch_word_i ( fetch_word ), .stall_o ( stall ),
    .rs1_addr_o    ( rs1_addr    ), .rs2_addr_o   ( rs2_addr   ),
    .rs1_data_i    ( rs1_data    ), .rs2_data_i   ( rs2_data   ),
    .alu_valid_o   ( alu_valid   ), .alu_rd_o     ( alu_rd     ), .alu_data_o ( alu_data ),
    .req_valid_o   ( req_d_valid ), .req_ready_i  ( req_d_ready ),
    .req_op_o      ( req_d_op    ), .req_arga_o   ( req_d_arga  ),
    .req_argb_o    ( req_d_argb  ), .req_id_o     ( req_d_id    ),
    .clear_valid_i ( clear_valid ), .clear_rd_i   ( clear_rd    ),
    .illegal_o
  );

  spill_register #(
    .width  ( 3 + 64 + id_width ),
    .bypass ( !reg_offload_req  )
  ) i_spill_req (
    .clk_i, .rst_i,
    .valid_i ( req_d_valid ), .ready_o ( req_d_ready ),
    .data_i  ( {req_d_op, req_d_arga, req_d_argb, req_d_id} ),
    .valid_o ( req_q_valid ), .ready_i ( req_q_ready ),
    .data_o  ( {req_q_op, req_q_arga, req_q_argb, req_q_id} )
  );

  cc_muldiv i_muldiv (
    .clk_i, .rst_i,
    .req_valid_i  ( req_q_valid  ), .req_ready_o  ( req_q_ready ),
    .req_op_i     ( req_q_op     ), .req_arga_i   ( req_q_arga  ),
    .req_argb_i   ( req_q_argb   ), .req_id_i     ( req_q_id    ),
    .resp_valid_o ( resp_d_valid ), .resp_ready_i ( resp_d_ready ),
    .resp_data_o  ( resp_d_data  ), .resp_id_o    ( resp_d_id    )
  );

  spill_register #(
    .width  ( 32 + id_width     ),
    .bypass ( !reg_offload_resp )
  ) i_spill_resp (
    .clk_i, .rst_i,
    .valid_i ( resp_d_valid ), .ready_o ( resp_d_ready ),
    .data_i  ( {resp_d_data, resp_d_id} ),
    .valid_o ( resp_q_valid ), .ready_i ( resp_q_ready ),
    .data_o  ( {resp_q_data, resp_q_id} )
  );

  cc_writeback i_writeback (
    .clk_i, .rst_i,
    .alu_valid_i   ( alu_valid    ), .alu_rd_i     ( alu_rd       ),
    .alu_data_i    ( alu_data     ),
    .resp_valid_i  ( resp_q_valid ), .resp_ready_o ( resp_q_ready ),
    .resp_data_i   ( resp_q_data  ), .resp_id_i    ( resp_q_id    ),
    .rs1_addr_i    ( rs1_addr     ), .rs2_addr_i   ( rs2_addr     ),
    .rs1_data_o    ( rs1_data     ), .rs2_data_o   ( rs2_data     ),
    .clear_valid_o ( clear_valid  ), .clear_rd_o   ( clear_rd     ),
    .retire_valid_o, .retire_rd_o, .retire_data_o
  );

endmodule

// File: sim/tb_clock.sv
module tb_clock #(
  parameter int period     = 40,
  parameter int rst_cycles = 8
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(period / 2) clk_o = ~clk_o;
  end

  // Release away from the rising edge
  initial begin
    rst_o = 1'b1;
    repeat (rst_cycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

// File: sim/tb_cc_complex.sv
module tb_cc_complex;

  import cc_pkg::*;

  localparam int max_prog = 512;

  logic        clk, rst;
  logic [31:0] inst_addr, inst_data;
  logic        inst_valid, inst_ready;
  logic        retire_valid, illegal, illegal_q;
  logic [4:0]  retire_rd;
  logic [31:0] retire_data;

  // Program and the expected result of each instruction
  logic [31:0] prog [max_prog];
  logic [4:0]  exp_rd [max_prog];
  logic [31:0] exp_val [max_prog];
  int          exp_test [max_prog];
  logic [31:0] ref_regs [32];
  int          n_prog, cur_test;

  // Oldest outstanding result per register
  logic        head_valid [32];
  logic [31:0] head_data [32];
  int          head_idx [32];

  int          remaining [7];
  int          checks [7];
  int          fails [7];
  string       names [7];
  int          total_left, total_fails, total_checks;
  int          illegal_cnt, cycles, timeout_limit;
  integer      seed;
  logic [31:0] exp_addr, xfer_addr, xfer_exp;
  logic        xfer_seen;

  logic [31:0] mul_ca [4] = '{32'h8000_0000, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff};
  logic [31:0] mul_cb [4] = '{32'hffff_ffff, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff};
  logic [31:0] div_ca [4] = '{32'h8000_0000, 32'd12345, 32'hffff_fff9, 32'h8000_0000};
  logic [31:0] div_cb [4] = '{32'hffff_ffff, 32'd0, 32'd2, 32'd0};

  tb_clock clock_gen (
    .clk_o ( clk ),
    .rst_o ( rst )
  );

  cc_complex uut (
    .clk_i          ( clk          ),
    .rst_i          ( rst          ),
    .inst_addr_o    ( inst_addr    ),
    .inst_data_i    ( inst_data    ),
    .inst_valid_o   ( inst_valid   ),
    .inst_ready_i   ( inst_ready   ),
    .retire_valid_o ( retire_valid ),
    .retire_rd_o    ( retire_rd    ),
    .retire_data_o  ( retire_data  ),
    .illegal_o      ( illegal      )
  );

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------
  function automatic logic [31:0] md_ref(logic [2:0] op, logic [31:0] a, logic [31:0] b);
    logic signed [63:0] sa, sb, prod_ss, prod_su;
    logic [63:0]        prod_uu;
    logic [31:0]        quo_s, rem_s;
    logic               ovf;
    sa      = {{32{a[31]}}, a};
    sb      = {{32{b[31]}}, b};
    prod_ss = sa * sb;
    prod_su = sa * $signed({32'd0, b});
    prod_uu = {32'd0, a} * {32'd0, b};
    ovf     = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    quo_s   = '0;
    rem_s   = '0;
    if (b != 32'd0 && !ovf) begin
      quo_s = $signed(a) / $signed(b);
      rem_s = $signed(a) % $signed(b);
    end
    case (op)
      md_mul:    return prod_ss[31:0];
      md_mulh:   return prod_ss[63:32];
      md_mulhsu: return prod_su[63:32];
      md_mulhu:  return prod_uu[63:32];
      md_div:    return (b == 32'd0) ? '1 : (ovf ? a : quo_s);
      md_divu:   return (b == 32'd0) ? '1 : a / b;
      md_rem:    return (b == 32'd0) ? a : (ovf ? 32'd0 : rem_s);
      default:   return (b == 32'd0) ? a : a % b;
    endcase
  endfunction

  task automatic emit(logic [31:0] word, logic [4:0] rd, logic [31:0] val);
    prog[n_prog]     = word;
    exp_rd[n_prog]   = rd;
    exp_val[n_prog]  = val;
    exp_test[n_prog] = cur_test;
    if (rd != 5'd0) begin
      ref_regs[rd] = val;
      remaining[cur_test]++;
      total_left++;
    end
    n_prog++;
  endtask

  task automatic addi_op(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    emit({imm, rs1, 3'b000, rd, opc_op_imm}, rd, ref_regs[rs1] + {{20{imm[11]}}, imm});
  endtask

  task automatic md_op(logic [2:0] op, logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
    emit({funct7_muldiv, rs2, rs1, op, rd, opc_op}, rd,
         md_ref(op, ref_regs[rs1], ref_regs[rs2]));
  endtask

  // Words that must not retire
  task automatic raw_word(logic [31:0] word);
    emit(word, 5'd0, 32'd0);
  endtask

  // Three signed 12-bit digits, scaled by 4096 held in x30
  task automatic load_const(logic [4:0] rd, logic [31:0] v);
    logic [31:0] r1, r2;
    logic [11:0] d0, d1;
    d0 = v[11:0];
    r1 = $signed(v - {{20{d0[11]}}, d0}) >>> 12;
    d1 = r1[11:0];
    r2 = $signed(r1 - {{20{d1[11]}}, d1}) >>> 12;
    addi_op(rd, 5'd0, r2[11:0]);
    md_op(md_mul, rd, rd, 5'd30);
    addi_op(rd, rd, d1);
    md_op(md_mul, rd, rd, 5'd30);
    addi_op(rd, rd, d0);
  endtask

  task automatic pair_ops(logic [31:0] a, logic [31:0] b, logic [2:0] base);
    load_const(5'd1, a);
    load_const(5'd2, b);
    for (int k = 0; k < 4; k++) begin
      md_op(base + 3'(k), 5'(10 + base + k), 5'd1, 5'd2);
    end
  endtask

  task automatic next_head(logic [4:0] rd, int from);
    head_valid[rd] = 1'b0;
    for (int i = from; i < n_prog && !head_valid[rd]; i++) begin
      if (exp_rd[i] == rd) begin
        head_valid[rd] = 1'b1;
        head_idx[rd]   = i;
        head_data[rd]  = exp_val[i];
      end
    end
  endtask

  task automatic count_error(int t);
    fails[t]++;
    total_fails++;
  endtask

  task automatic retire_done(logic [4:0] rd);
    int t;
    t = exp_test[head_idx[rd]];
    checks[t]++;
    remaining[t]--;
    total_left--;
    next_head(rd, head_idx[rd] + 1);
    if (remaining[t] == 0) begin
      if (t == 5) begin
        checks[5]++;
        assert (illegal_cnt == 2) else begin
          $display("illegal_o pulsed %0d times, two illegal words were sent", illegal_cnt);
          count_error(5);
        end
      end
      $display("Test %0d (%s) finished: %0d checks, %0d errors",
               t, names[t], checks[t], fails[t]);
    end
  endtask

  function automatic logic [31:0] fetch_word(logic [31:0] addr);
    int idx;
    idx = int'((addr - boot_addr) >> 2);
    if (idx >= 0 && idx < n_prog) begin
      return prog[idx];
    end
    return {12'd0, 5'd0, 3'b000, 5'd0, opc_op_imm};
  endfunction

  // ------------------------------------------------------------
  // Instruction memory and bookkeeping
  // ------------------------------------------------------------
  always @(negedge clk) begin
    inst_ready <= ($random(seed) & 32'd3) != 32'd0;
    inst_data  <= fetch_word(inst_addr);
  end

  always @(posedge clk) begin
    if (!rst) begin
      cycles++;
      illegal_q <= illegal;
      xfer_seen <= inst_valid && inst_ready;
      if (illegal) begin
        illegal_cnt++;
        checks[5]++;
      end
      if (inst_valid && inst_ready) begin
        xfer_addr <= inst_addr;
        xfer_exp  <= exp_addr;
        exp_addr  <= exp_addr + 32'd4;
        checks[6]++;
      end
      if (retire_valid && retire_rd != 5'd0 && head_valid[retire_rd]) begin
        retire_done(retire_rd);
      end else if (retire_valid) begin
        checks[0]++;
      end
      if (cycles > timeout_limit) begin
        $display("Run timed out after %0d cycles, %0d results never retired",
                 cycles, total_left);
        $display("TEST FAILED");
        $finish;
      end
    end
  end

  // ------------------------------------------------------------
  // Assertions, sampled mid-cycle
  // ------------------------------------------------------------
  a_x0_zero: assert property (@(negedge clk) disable iff (rst)
    retire_valid && retire_rd == 5'd0 |-> retire_data == 32'd0)
    else begin
      $display("Fail %0t: x0 retired %h", $time, retire_data);
      count_error(0);
    end

  a_expected: assert property (@(negedge clk) disable iff (rst)
    retire_valid && retire_rd != 5'd0 |-> head_valid[retire_rd])
    else begin
      $display("Retire on x%0d at %0t has no instruction waiting for it", retire_rd, $time);
      count_error(0);
    end

  a_value: assert property (@(negedge clk) disable iff (rst)
    retire_valid && retire_rd != 5'd0 && head_valid[retire_rd] |->
      retire_data == head_data[retire_rd])
    else begin
      $display("Fail %0t: x%0d retired %h, expected %h", $time, retire_rd, retire_data,
               head_data[retire_rd]);
      count_error(exp_test[head_idx[retire_rd]]);
    end

  a_fetch_addr: assert property (@(negedge clk) disable iff (rst)
    xfer_seen |-> xfer_addr == xfer_exp)
    else begin
      $display("Fail %0t: fetch from %h, expected %h", $time, xfer_addr, xfer_exp);
      count_error(6);
    end

  a_illegal_pulse: assert property (@(negedge clk) disable iff (rst)
    illegal |-> !illegal_q)
    else begin
      $display("illegal_o stayed high for two cycles at %0t", $time);
      count_error(5);
    end

  // ------------------------------------------------------------
  // Program and run
  // ------------------------------------------------------------
  initial begin
    logic [31:0] a, b;
    seed       = 32'h93585d75;
    inst_ready = 1'b0;
    inst_data  = 32'd0;
    illegal_q  = 1'b0;
    xfer_seen  = 1'b0;
    exp_addr   = boot_addr;
    names      = '{"other retires", "ADDI chains", "multiply", "divide",
                   "dependencies", "illegal words", "fetch addresses"};
    for (int r = 0; r < 32; r++) begin
      ref_regs[r] = 32'd0;
    end

    cur_test = 1;
    addi_op(5'd1, 5'd0, 12'd100);
    addi_op(5'd2, 5'd1, -12'sd300);
    addi_op(5'd3, 5'd2, 12'd2047);
    addi_op(5'd4, 5'd3, -12'sd2048);
    addi_op(5'd0, 5'd4, 12'd55);
    addi_op(5'd5, 5'd0, -12'sd1);
    addi_op(5'd6, 5'd0, 12'd0);
    addi_op(5'd7, 5'd5, -12'sd2048);

    cur_test = 2;
    addi_op(5'd30, 5'd0, 12'd64);
    md_op(md_mul, 5'd30, 5'd30, 5'd30);
    for (int i = 0; i < 7; i++) begin
      a = $random(seed);
      b = $random(seed);
      if (i < 4) begin
        a = mul_ca[i];
        b = mul_cb[i];
      end
      pair_ops(a, b, md_mul);
    end

    cur_test = 3;
    for (int i = 0; i < 7; i++) begin
      a = $random(seed);
      b = $random(seed);
      if (i < 4) begin
        a = div_ca[i];
        b = div_cb[i];
      end
      pair_ops(a, b, md_div);
    end

    cur_test = 4;
    md_op(md_div, 5'd5, 5'd1, 5'd2);
    addi_op(5'd6, 5'd5, 12'd1);
    md_op(md_rem, 5'd7, 5'd1, 5'd2);
    md_op(md_mul, 5'd7, 5'd2, 5'd2);
    md_op(md_mul, 5'd8, 5'd1, 5'd2);
    md_op(md_mulhu, 5'd9, 5'd2, 5'd1);
    md_op(md_mulh, 5'd10, 5'd8, 5'd9);
    md_op(md_divu, 5'd11, 5'd10, 5'd6);
    addi_op(5'd12, 5'd11, -12'sd5);

    cur_test = 5;
    addi_op(5'd20, 5'd0, 12'd5);
    // ADD x21, x1, x2
    raw_word({7'b0000000, 5'd2, 5'd1, 3'b000, 5'd21, opc_op});
    addi_op(5'd22, 5'd20, 12'd1);
    // Opcode 1111111 with rd x23
    raw_word(32'h0000_0bff);
    addi_op(5'd24, 5'd22, -12'sd3);

    timeout_limit = 40 * n_prog + 200;
    for (int r = 1; r < 32; r++) begin
      next_head(5'(r), 0);
    end

    wait (total_left == 0);
    repeat (20) @(posedge clk);
    $display("Test 0 (%s) finished: %0d checks, %0d errors", names[0], checks[0], fails[0]);
    $display("Test 6 (%s) finished: %0d checks, %0d errors", names[6], checks[6], fails[6]);
    for (int t = 0; t < 7; t++) begin
      total_checks += checks[t];
    end
    $display("Checks: %0d passed, %0d failed", total_checks - total_fails, total_fails);
    if (total_fails == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: compile.f
hdl/cc_pkg.sv
hdl/spill_register.sv
hdl/cc_fetch.sv
hdl/cc_core.sv
hdl/cc_muldiv.sv
hdl/cc_writeback.sv
hdl/cc_complex.sv
sim/tb_clock.sv
sim/tb_cc_complex.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cc_complex
RTL_TOP   ?= cc_complex
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST OK$$" $(LOG) && echo "Simulation passed" || \
	  (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
